// ==== inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input wire [31:0] instr,
	input wire valid,
	output issue_pkg::decode_t ctl
);

	// funct7, funct3 and opcode side by side for wildcard matching
	logic [16:0] key;

	assign key = {instr[31:25], instr[14:12], instr[6:0]};

	// shared alu map for op and op-imm, alt picks sub or sra
	function automatic issue_pkg::alu_func_e base_func(input logic [2:0] funct3, input logic alt);
		issue_pkg::alu_func_e func;
		case (funct3)
			issue_pkg::F3_ADD_SUB: func = alt ? issue_pkg::ALU_SUB : issue_pkg::ALU_ADD;
			issue_pkg::F3_SLL:     func = issue_pkg::ALU_SLL;
			issue_pkg::F3_SLT:     func = issue_pkg::ALU_SLT;
			issue_pkg::F3_SLTU:    func = issue_pkg::ALU_SLTU;
			issue_pkg::F3_XOR:     func = issue_pkg::ALU_XOR;
			issue_pkg::F3_SRL_SRA: func = alt ? issue_pkg::ALU_SRA : issue_pkg::ALU_SRL;
			issue_pkg::F3_OR:      func = issue_pkg::ALU_OR;
			default:               func = issue_pkg::ALU_AND;
		endcase
		return func;
	endfunction

	always_comb begin
		// noop defaults
		ctl = '0;
		ctl.opa_sel = issue_pkg::OPA_IS_RS1;
		ctl.opb_sel = issue_pkg::OPB_IS_RS2;
		ctl.alu_func = issue_pkg::ALU_ADD;
		ctl.unit = issue_pkg::UNIT_ALU;
		if (valid) begin
			casez (key)
				{7'b???????, 3'b???, issue_pkg::OP_LUI}: begin
					ctl.dest_valid = 1'b1;
					ctl.opa_sel = issue_pkg::OPA_IS_ZERO;
					ctl.opb_sel = issue_pkg::OPB_IS_U_IMM;
				end
				{7'b???????, 3'b???, issue_pkg::OP_AUIPC}: begin
					ctl.dest_valid = 1'b1;
					ctl.opa_sel = issue_pkg::OPA_IS_PC;
					ctl.opb_sel = issue_pkg::OPB_IS_U_IMM;
				end
				{7'b???????, 3'b???, issue_pkg::OP_JAL}: begin
					ctl.dest_valid = 1'b1;
					ctl.opa_sel = issue_pkg::OPA_IS_PC;
					ctl.opb_sel = issue_pkg::OPB_IS_J_IMM;
					ctl.uncond_branch = 1'b1;
				end
				{7'b???????, 3'b000, issue_pkg::OP_JALR}: begin
					ctl.dest_valid = 1'b1;
					ctl.opb_sel = issue_pkg::OPB_IS_I_IMM;
					ctl.uncond_branch = 1'b1;
				end
				{7'b???????, issue_pkg::F3_BEQ, issue_pkg::OP_BRANCH},
				{7'b???????, issue_pkg::F3_BNE, issue_pkg::OP_BRANCH},
				{7'b???????, issue_pkg::F3_BLT, issue_pkg::OP_BRANCH},
				{7'b???????, issue_pkg::F3_BGE, issue_pkg::OP_BRANCH},
				{7'b???????, issue_pkg::F3_BLTU, issue_pkg::OP_BRANCH},
				{7'b???????, issue_pkg::F3_BGEU, issue_pkg::OP_BRANCH}: begin
					ctl.opa_sel = issue_pkg::OPA_IS_PC;
					ctl.opb_sel = issue_pkg::OPB_IS_B_IMM;
					ctl.cond_branch = 1'b1;
					ctl.unit = issue_pkg::UNIT_BRANCH;
				end
				{7'b???????, issue_pkg::F3_BYTE, issue_pkg::OP_LOAD},
				{7'b???????, issue_pkg::F3_HALF, issue_pkg::OP_LOAD},
				{7'b???????, issue_pkg::F3_WORD, issue_pkg::OP_LOAD},
				{7'b???????, issue_pkg::F3_BYTE_U, issue_pkg::OP_LOAD},
				{7'b???????, issue_pkg::F3_HALF_U, issue_pkg::OP_LOAD}: begin
					ctl.dest_valid = 1'b1;
					ctl.opb_sel = issue_pkg::OPB_IS_I_IMM;
					ctl.rd_mem = 1'b1;
					ctl.unit = issue_pkg::UNIT_LOAD;
				end
				{7'b???????, issue_pkg::F3_BYTE, issue_pkg::OP_STORE},
				{7'b???????, issue_pkg::F3_HALF, issue_pkg::OP_STORE},
				{7'b???????, issue_pkg::F3_WORD, issue_pkg::OP_STORE}: begin
					ctl.opb_sel = issue_pkg::OPB_IS_S_IMM;
					ctl.wr_mem = 1'b1;
					ctl.unit = issue_pkg::UNIT_STORE;
				end
				// immediate forms, upper bits are part of the immediate
				{7'b???????, issue_pkg::F3_ADD_SUB, issue_pkg::OP_IMM},
				{7'b???????, issue_pkg::F3_SLT, issue_pkg::OP_IMM},
				{7'b???????, issue_pkg::F3_SLTU, issue_pkg::OP_IMM},
				{7'b???????, issue_pkg::F3_XOR, issue_pkg::OP_IMM},
				{7'b???????, issue_pkg::F3_OR, issue_pkg::OP_IMM},
				{7'b???????, issue_pkg::F3_AND, issue_pkg::OP_IMM},
				{issue_pkg::F7_BASE, issue_pkg::F3_SLL, issue_pkg::OP_IMM},
				{issue_pkg::F7_BASE, issue_pkg::F3_SRL_SRA, issue_pkg::OP_IMM},
				{issue_pkg::F7_ALT, issue_pkg::F3_SRL_SRA, issue_pkg::OP_IMM}: begin
					ctl.dest_valid = 1'b1;
					ctl.opb_sel = issue_pkg::OPB_IS_I_IMM;
					ctl.alu_func = base_func(instr[14:12],
						instr[30] && instr[14:12] == issue_pkg::F3_SRL_SRA);
				end
				{issue_pkg::F7_BASE, 3'b???, issue_pkg::OP_REG},
				{issue_pkg::F7_ALT, issue_pkg::F3_ADD_SUB, issue_pkg::OP_REG},
				{issue_pkg::F7_ALT, issue_pkg::F3_SRL_SRA, issue_pkg::OP_REG}: begin
					ctl.dest_valid = 1'b1;
					ctl.alu_func = base_func(instr[14:12], instr[30]);
				end
				{issue_pkg::F7_MULDIV, issue_pkg::F3_MUL, issue_pkg::OP_REG},
				{issue_pkg::F7_MULDIV, issue_pkg::F3_MULH, issue_pkg::OP_REG},
				{issue_pkg::F7_MULDIV, issue_pkg::F3_MULHSU, issue_pkg::OP_REG},
				{issue_pkg::F7_MULDIV, issue_pkg::F3_MULHU, issue_pkg::OP_REG}: begin
					ctl.dest_valid = 1'b1;
					ctl.unit = issue_pkg::UNIT_MULT;
					case (instr[13:12])
						2'b00:   ctl.alu_func = issue_pkg::ALU_MUL;
						2'b01:   ctl.alu_func = issue_pkg::ALU_MULH;
						2'b10:   ctl.alu_func = issue_pkg::ALU_MULHSU;
						default: ctl.alu_func = issue_pkg::ALU_MULHU;
					endcase
				end
				{7'b???????, issue_pkg::F3_CSRRW, issue_pkg::OP_SYSTEM},
				{7'b???????, issue_pkg::F3_CSRRS, issue_pkg::OP_SYSTEM},
				{7'b???????, issue_pkg::F3_CSRRC, issue_pkg::OP_SYSTEM}: begin
					ctl.csr_op = 1'b1;
				end
				{7'b???????, 3'b000, issue_pkg::OP_SYSTEM}: begin
					// only wfi is supported here, it stops the core
					if (instr == issue_pkg::WFI_INST)
						ctl.halt = 1'b1;
					else
						ctl.illegal = 1'b1;
				end
				default: ctl.illegal = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== issue_pkg.sv ====
`default_nettype none

package issue_pkg;

	//////////////////////////////////////////////////
	// sizes and unit budgets
	//////////////////////////////////////////////////

	localparam int N_WAY = 3;
	localparam int XLEN = 32;
	localparam int N_PHY_REG = 64;
	localparam int TAG_BITS = $clog2(N_PHY_REG);
	localparam logic [TAG_BITS-1:0] ZERO_TAG = '0;

	// ranks run 0 to N_WAY, 0 marks an empty slot
	localparam int AGE_BITS = $clog2(N_WAY + 1);
	localparam int CNT_BITS = $clog2(N_WAY + 1);

	localparam int EX_ALU_UNITS = 2;
	localparam int EX_MULT_UNITS = 1;
	localparam int EX_LOAD_UNITS = 1;
	localparam int EX_STORE_UNITS = 1;
	localparam int EX_BRANCH_UNITS = 1;
	localparam int N_UNITS = 5;

	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [XLEN-1:0] word_t;
	typedef logic [AGE_BITS-1:0] age_t;
	typedef logic [CNT_BITS-1:0] cnt_t;

	//////////////////////////////////////////////////
	// rv32 encodings
	//////////////////////////////////////////////////

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	// alu group
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// m extension, multiply half only
	localparam logic [2:0] F3_MUL = 3'b000;
	localparam logic [2:0] F3_MULH = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU = 3'b011;

	// branch conditions
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// memory access widths
	localparam logic [2:0] F3_BYTE = 3'b000;
	localparam logic [2:0] F3_HALF = 3'b001;
	localparam logic [2:0] F3_WORD = 3'b010;
	localparam logic [2:0] F3_BYTE_U = 3'b100;
	localparam logic [2:0] F3_HALF_U = 3'b101;

	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [2:0] F3_CSRRC = 3'b011;
	localparam logic [31:0] WFI_INST = 32'h10500073;

	//////////////////////////////////////////////////
	// enums and packets
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM, OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
	} opb_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
	} alu_func_e;

	typedef enum logic [2:0] {UNIT_ALU, UNIT_MULT, UNIT_LOAD, UNIT_STORE, UNIT_BRANCH} exec_unit_e;

	typedef struct packed {
		logic valid;
		logic [31:0] inst;
		word_t pc;
		tag_t src1_tag;
		tag_t src2_tag;
		tag_t dest_tag;
	} dispatch_t;

	typedef struct packed {
		opa_sel_e opa_sel;
		opb_sel_e opb_sel;
		alu_func_e alu_func;
		logic rd_mem;
		logic wr_mem;
		logic cond_branch;
		logic uncond_branch;
		logic csr_op;
		logic halt;
		logic illegal;
		logic dest_valid;
		exec_unit_e unit;
	} decode_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		logic [31:0] inst;
		word_t rs1_value;
		word_t rs2_value;
		tag_t dest_tag;
		decode_t ctl;
	} ex_packet_t;

	typedef struct packed {
		logic en;
		tag_t tag;
		word_t data;
	} wb_t;

	typedef struct packed {
		logic busy;
		age_t age;
		ex_packet_t pkt;
	} held_entry_t;

endpackage

`default_nettype wire

// ==== issue_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_select (
	input wire issue_pkg::held_entry_t [issue_pkg::N_WAY-1:0] held,
	input wire issue_pkg::ex_packet_t [issue_pkg::N_WAY-1:0] fresh,
	output issue_pkg::ex_packet_t [issue_pkg::N_WAY-1:0] issue_packet,
	output logic [issue_pkg::N_WAY-1:0] held_taken,
	output logic [issue_pkg::N_WAY-1:0] fresh_defer
);

	always_comb begin
		issue_pkg::cnt_t slot;
		issue_pkg::cnt_t budget [issue_pkg::N_UNITS];
		issue_pkg::exec_unit_e unit;
		issue_pkg::age_t rank;

		//////////////////////////////////////////////////
		// fresh budgets every cycle
		//////////////////////////////////////////////////
		budget[issue_pkg::UNIT_ALU] = issue_pkg::cnt_t'(issue_pkg::EX_ALU_UNITS);
		budget[issue_pkg::UNIT_MULT] = issue_pkg::cnt_t'(issue_pkg::EX_MULT_UNITS);
		budget[issue_pkg::UNIT_LOAD] = issue_pkg::cnt_t'(issue_pkg::EX_LOAD_UNITS);
		budget[issue_pkg::UNIT_STORE] = issue_pkg::cnt_t'(issue_pkg::EX_STORE_UNITS);
		budget[issue_pkg::UNIT_BRANCH] = issue_pkg::cnt_t'(issue_pkg::EX_BRANCH_UNITS);
		slot = '0;
		unit = issue_pkg::UNIT_ALU;
		rank = '0;

		// unused output slots stay all zero
		issue_packet = '0;
		held_taken = '0;
		fresh_defer = '0;

		//////////////////////////////////////////////////
		// held entries, oldest rank first
		//////////////////////////////////////////////////
		for (int r = 1; r <= issue_pkg::N_WAY; r++) begin
			rank = issue_pkg::age_t'(r);
			for (int j = 0; j < issue_pkg::N_WAY; j++) begin
				unit = held[j].pkt.ctl.unit;
				if (held[j].busy && held[j].age == rank &&
						slot < issue_pkg::cnt_t'(issue_pkg::N_WAY) && budget[unit] != '0) begin
					issue_packet[slot] = held[j].pkt;
					held_taken[j] = 1'b1;
					budget[unit] = budget[unit] - 1'b1;
					slot = slot + 1'b1;
				end
			end
		end

		//////////////////////////////////////////////////
		// new lanes in lane order
		//////////////////////////////////////////////////
		for (int i = 0; i < issue_pkg::N_WAY; i++) begin
			unit = fresh[i].ctl.unit;
			if (fresh[i].valid) begin
				if (slot < issue_pkg::cnt_t'(issue_pkg::N_WAY) && budget[unit] != '0) begin
					issue_packet[slot] = fresh[i];
					budget[unit] = budget[unit] - 1'b1;
					slot = slot + 1'b1;
				end else begin
					// goes to the holding buffer
					fresh_defer[i] = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== issue_stage.f ====
issue_pkg.sv
inst_decoder.sv
phys_regfile.sv
issue_select.sv
ready_buffer.sv
issue_stage.sv
issue_stage_tb.sv

// ==== issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input wire clock,
	input wire reset,
	input wire issue_pkg::dispatch_t [issue_pkg::N_WAY-1:0] dispatch,
	input wire issue_pkg::wb_t [issue_pkg::N_WAY-1:0] wb,
	output issue_pkg::ex_packet_t [issue_pkg::N_WAY-1:0] issue_packet,
	output issue_pkg::cnt_t issue_num,
	output issue_pkg::tag_t [issue_pkg::N_WAY-1:0] ex_dest_tag
);

	issue_pkg::decode_t [issue_pkg::N_WAY-1:0] ctl;
	issue_pkg::tag_t [issue_pkg::N_WAY-1:0] rda_idx;
	issue_pkg::tag_t [issue_pkg::N_WAY-1:0] rdb_idx;
	issue_pkg::word_t [issue_pkg::N_WAY-1:0] rda_out;
	issue_pkg::word_t [issue_pkg::N_WAY-1:0] rdb_out;
	issue_pkg::ex_packet_t [issue_pkg::N_WAY-1:0] fresh;
	issue_pkg::held_entry_t [issue_pkg::N_WAY-1:0] held;
	logic [issue_pkg::N_WAY-1:0] held_taken;
	logic [issue_pkg::N_WAY-1:0] fresh_defer;

	for (genvar lane = 0; lane < issue_pkg::N_WAY; lane++) begin : g_dec
		inst_decoder u_dec (
			.instr(dispatch[lane].inst),
			.valid(dispatch[lane].valid),
			.ctl(ctl[lane])
		);
	end

	//////////////////////////////////////////////////
	// new candidates from dispatch, decode and operands
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < issue_pkg::N_WAY; i++) begin
			rda_idx[i] = dispatch[i].src1_tag;
			rdb_idx[i] = dispatch[i].src2_tag;
			fresh[i].valid = dispatch[i].valid;
			fresh[i].pc = dispatch[i].pc;
			fresh[i].inst = dispatch[i].inst;
			fresh[i].rs1_value = rda_out[i];
			fresh[i].rs2_value = rdb_out[i];
			// no register write means no destination tag
			fresh[i].dest_tag = ctl[i].dest_valid ? dispatch[i].dest_tag : issue_pkg::ZERO_TAG;
			fresh[i].ctl = ctl[i];
			ex_dest_tag[i] = issue_packet[i].valid ? issue_packet[i].dest_tag : '0;
		end
	end

	phys_regfile u_regfile (
		.clock(clock),
		.rda_idx(rda_idx),
		.rdb_idx(rdb_idx),
		.rda_out(rda_out),
		.rdb_out(rdb_out),
		.wb(wb)
	);

	issue_select u_select (
		.held(held),
		.fresh(fresh),
		.issue_packet(issue_packet),
		.held_taken(held_taken),
		.fresh_defer(fresh_defer)
	);

	ready_buffer u_buffer (
		.clock(clock),
		.reset(reset),
		.held_taken(held_taken),
		.fresh_defer(fresh_defer),
		.fresh(fresh),
		.held(held),
		.free_count(issue_num)
	);

endmodule

`default_nettype wire

// ==== issue_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage_tb;

	localparam int N = issue_pkg::N_WAY;
	localparam int RESET_CYCLES = 10;
	localparam int PRELOAD_CYCLES = (issue_pkg::N_PHY_REG - 1 + N - 1) / N;
	localparam int DEC_ROWS = 13;
	localparam int MAIN_ROWS = 8;
	localparam int CYCLE_LIMIT = RESET_CYCLES + 1 + PRELOAD_CYCLES + DEC_ROWS + MAIN_ROWS + 20;
	localparam int DEC_PC = 32'h1000;

	localparam logic [31:0] INST_MUL = 32'h022081b3;
	localparam logic [31:0] INST_LW = 32'h0040a183;
	localparam logic [31:0] INST_ADDI = 32'h00500093;
	localparam logic [31:0] INST_BEQ = 32'h00208463;

	// one cycle of stimulus and the outputs it should give
	typedef struct packed {
		issue_pkg::dispatch_t [N-1:0] lanes;
		issue_pkg::wb_t [N-1:0] wb;
		issue_pkg::word_t [N-1:0] exp_pc;
		issue_pkg::cnt_t exp_num;
		issue_pkg::tag_t [N-1:0] exp_tag;
	} row_t;

	logic clock;
	logic reset;
	issue_pkg::dispatch_t [N-1:0] dispatch;
	issue_pkg::wb_t [N-1:0] wb;
	issue_pkg::ex_packet_t [N-1:0] issue_packet;
	issue_pkg::cnt_t issue_num;
	issue_pkg::tag_t [N-1:0] ex_dest_tag;

	issue_pkg::word_t shadow [issue_pkg::N_PHY_REG];
	issue_pkg::word_t exp_rs1 [issue_pkg::word_t];
	issue_pkg::word_t exp_rs2 [issue_pkg::word_t];
	logic [31:0] exp_inst [issue_pkg::word_t];
	row_t rows [MAIN_ROWS];
	logic [31:0] dec_inst [DEC_ROWS];
	issue_pkg::decode_t dec_ctl [DEC_ROWS];
	logic [31:0] rng_state = 32'hca87698f;
	int cycles = 0;
	int issue_errors = 0;
	int operand_errors = 0;
	int decode_errors = 0;

	issue_stage uut (
		.clock(clock),
		.reset(reset),
		.dispatch(dispatch),
		.wb(wb),
		.issue_packet(issue_packet),
		.issue_num(issue_num),
		.ex_dest_tag(ex_dest_tag)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic issue_pkg::dispatch_t lane(input logic [31:0] inst, input int pc,
			input int s1, input int s2, input int d);
		issue_pkg::dispatch_t l;
		l.valid = 1'b1;
		l.inst = inst;
		l.pc = issue_pkg::word_t'(pc);
		l.src1_tag = issue_pkg::tag_t'(s1);
		l.src2_tag = issue_pkg::tag_t'(s2);
		l.dest_tag = issue_pkg::tag_t'(d);
		return l;
	endfunction

	function automatic issue_pkg::wb_t port(input int tag);
		issue_pkg::wb_t w;
		w.en = 1'b1;
		w.tag = issue_pkg::tag_t'(tag);
		w.data = '0;
		return w;
	endfunction

	// flags are rd_mem, wr_mem, cond, uncond, csr, halt, illegal, dest_valid
	function automatic issue_pkg::decode_t make_ctl(input issue_pkg::opa_sel_e opa,
			input issue_pkg::opb_sel_e opb, input issue_pkg::alu_func_e func,
			input issue_pkg::exec_unit_e unit, input logic [7:0] flags);
		issue_pkg::decode_t c;
		c = '0;
		c.opa_sel = opa;
		c.opb_sel = opb;
		c.alu_func = func;
		c.unit = unit;
		{c.rd_mem, c.wr_mem, c.cond_branch, c.uncond_branch,
			c.csr_op, c.halt, c.illegal, c.dest_valid} = flags;
		return c;
	endfunction

	// zero tag first, then the highest matching writeback, then the stored value
	function automatic issue_pkg::word_t expected_operand(input issue_pkg::tag_t tag,
			input issue_pkg::wb_t [N-1:0] ports);
		if (tag == issue_pkg::ZERO_TAG)
			return '0;
		for (int p = N - 1; p >= 0; p--) begin
			if (ports[p].en && ports[p].tag == tag)
				return ports[p].data;
		end
		return shadow[tag];
	endfunction

	task automatic set_expect(input int r, input int p0, input int p1, input int p2,
			input int num, input int t0, input int t1, input int t2);
		rows[r].exp_pc[0] = issue_pkg::word_t'(p0);
		rows[r].exp_pc[1] = issue_pkg::word_t'(p1);
		rows[r].exp_pc[2] = issue_pkg::word_t'(p2);
		rows[r].exp_num = issue_pkg::cnt_t'(num);
		rows[r].exp_tag[0] = issue_pkg::tag_t'(t0);
		rows[r].exp_tag[1] = issue_pkg::tag_t'(t1);
		rows[r].exp_tag[2] = issue_pkg::tag_t'(t2);
	endtask

	//////////////////////////////////////////////////
	// stimulus tables
	//////////////////////////////////////////////////
	task automatic fill_decode_table();
		dec_inst[0] = 32'h123452b7;
		dec_ctl[0] = make_ctl(issue_pkg::OPA_IS_ZERO, issue_pkg::OPB_IS_U_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0000_0001);
		dec_inst[1] = 32'h00001317;
		dec_ctl[1] = make_ctl(issue_pkg::OPA_IS_PC, issue_pkg::OPB_IS_U_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0000_0001);
		dec_inst[2] = 32'h008000ef;
		dec_ctl[2] = make_ctl(issue_pkg::OPA_IS_PC, issue_pkg::OPB_IS_J_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0001_0001);
		dec_inst[3] = 32'h000100e7;
		dec_ctl[3] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_I_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0001_0001);
		dec_inst[4] = INST_BEQ;
		dec_ctl[4] = make_ctl(issue_pkg::OPA_IS_PC, issue_pkg::OPB_IS_B_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_BRANCH, 8'b0010_0000);
		dec_inst[5] = INST_LW;
		dec_ctl[5] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_I_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_LOAD, 8'b1000_0001);
		dec_inst[6] = 32'h0020a223;
		dec_ctl[6] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_S_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_STORE, 8'b0100_0000);
		dec_inst[7] = INST_ADDI;
		dec_ctl[7] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_I_IMM,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0000_0001);
		dec_inst[8] = 32'h402081b3;
		dec_ctl[8] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_RS2,
			issue_pkg::ALU_SUB, issue_pkg::UNIT_ALU, 8'b0000_0001);
		dec_inst[9] = INST_MUL;
		dec_ctl[9] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_RS2,
			issue_pkg::ALU_MUL, issue_pkg::UNIT_MULT, 8'b0000_0001);
		dec_inst[10] = 32'h30009073;
		dec_ctl[10] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_RS2,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0000_1000);
		dec_inst[11] = 32'h10500073;
		dec_ctl[11] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_RS2,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0000_0100);
		dec_inst[12] = 32'hffffffff;
		dec_ctl[12] = make_ctl(issue_pkg::OPA_IS_RS1, issue_pkg::OPB_IS_RS2,
			issue_pkg::ALU_ADD, issue_pkg::UNIT_ALU, 8'b0000_0010);
	endtask

	task automatic fill_main_table();
		for (int r = 0; r < MAIN_ROWS; r++)
			rows[r] = '0;
		// three muls against the single mult unit
		rows[0].lanes[0] = lane(INST_MUL, 32'h100, 5, 6, 20);
		rows[0].lanes[1] = lane(INST_MUL, 32'h104, 7, 0, 21);
		rows[0].lanes[2] = lane(INST_MUL, 32'h108, 8, 9, 22);
		rows[0].wb[0] = port(5);
		set_expect(0, 32'h100, 0, 0, 1, 20, 0, 0);
		// late mul lands in the slot ahead of an older one
		rows[1].lanes[0] = lane(INST_MUL, 32'h10c, 23, 24, 23);
		set_expect(1, 32'h104, 0, 0, 1, 21, 0, 0);
		// held muls drain by age and not by slot
		set_expect(2, 32'h108, 0, 0, 2, 22, 0, 0);
		set_expect(3, 32'h10c, 0, 0, 3, 23, 0, 0);
		// second load waits for the load unit
		rows[4].lanes[0] = lane(INST_LW, 32'h200, 10, 0, 30);
		rows[4].lanes[1] = lane(INST_LW, 32'h204, 11, 0, 31);
		rows[4].lanes[2] = lane(INST_ADDI, 32'h208, 12, 0, 32);
		// zero tag write is dropped
		rows[4].wb[0] = port(0);
		// higher port wins the clash on tag 12
		rows[4].wb[1] = port(12);
		rows[4].wb[2] = port(12);
		set_expect(4, 32'h200, 32'h208, 0, 2, 30, 32, 0);
		// held load goes ahead of the new load
		rows[5].lanes[0] = lane(INST_LW, 32'h20c, 13, 14, 33);
		rows[5].lanes[1] = lane(INST_ADDI, 32'h210, 0, 15, 34);
		set_expect(5, 32'h204, 32'h210, 0, 2, 31, 34, 0);
		// branch writes no register so its tag reads zero
		rows[6].lanes[0] = lane(INST_MUL, 32'h214, 16, 17, 35);
		rows[6].lanes[1] = lane(INST_BEQ, 32'h218, 18, 19, 36);
		set_expect(6, 32'h20c, 32'h214, 32'h218, 3, 33, 35, 0);
		set_expect(7, 0, 0, 0, 3, 0, 0, 0);
	endtask

	//////////////////////////////////////////////////
	// drive and check
	//////////////////////////////////////////////////
	task automatic check_outputs(input row_t row);
		issue_pkg::ex_packet_t pkt;
		issue_pkg::word_t pc;
		for (int k = 0; k < N; k++) begin
			pkt = issue_packet[k];
			pc = row.exp_pc[k];
			if (pc == '0) begin
				assert (pkt == '0 && ex_dest_tag[k] == '0) else begin
					issue_errors++;
					$display("ERR %0t: slot %0d not empty, valid %b pc %h tag %0d",
						$time, k, pkt.valid, pkt.pc, ex_dest_tag[k]);
				end
			end else begin
				assert (pkt.valid && pkt.pc == pc && exp_inst.exists(pc) &&
						pkt.inst == exp_inst[pc]) else begin
					issue_errors++;
					$display("ERR %0t: slot %0d valid %b pc %h inst %h, expected pc %h inst %h",
						$time, k, pkt.valid, pkt.pc, pkt.inst, pc, exp_inst[pc]);
				end
				assert (pkt.dest_tag == row.exp_tag[k] && ex_dest_tag[k] == row.exp_tag[k])
				else begin
					issue_errors++;
					$display("ERR %0t: slot %0d dest tag %0d ex_dest_tag %0d, expected %0d",
						$time, k, pkt.dest_tag, ex_dest_tag[k], row.exp_tag[k]);
				end
				assert (exp_rs1.exists(pc) && pkt.rs1_value == exp_rs1[pc] &&
						pkt.rs2_value == exp_rs2[pc]) else begin
					operand_errors++;
					$display("ERR %0t: pc %h operands %h %h, expected %h %h", $time, pc,
						pkt.rs1_value, pkt.rs2_value, exp_rs1[pc], exp_rs2[pc]);
				end
			end
		end
		assert (issue_num == row.exp_num) else begin
			issue_errors++;
			$display("ERR %0t: issue_num %0d, expected %0d", $time, issue_num, row.exp_num);
		end
	endtask

	task automatic apply_row(input row_t row);
		issue_pkg::wb_t [N-1:0] ports;
		ports = row.wb;
		for (int p = 0; p < N; p++) begin
			if (ports[p].en)
				ports[p].data = next_rand();
		end
		// operands are captured when an instruction is dispatched
		for (int i = 0; i < N; i++) begin
			if (row.lanes[i].valid) begin
				exp_inst[row.lanes[i].pc] = row.lanes[i].inst;
				exp_rs1[row.lanes[i].pc] = expected_operand(row.lanes[i].src1_tag, ports);
				exp_rs2[row.lanes[i].pc] = expected_operand(row.lanes[i].src2_tag, ports);
			end
		end
		@(posedge clock);
		dispatch <= row.lanes;
		wb <= ports;
		@(negedge clock);
		check_outputs(row);
		for (int p = 0; p < N; p++) begin
			if (ports[p].en && ports[p].tag != issue_pkg::ZERO_TAG)
				shadow[ports[p].tag] = ports[p].data;
		end
	endtask

	task automatic preload_registers();
		issue_pkg::wb_t [N-1:0] ports;
		for (int base = 1; base < issue_pkg::N_PHY_REG; base += N) begin
			ports = '0;
			for (int p = 0; p < N; p++) begin
				if (base + p < issue_pkg::N_PHY_REG) begin
					ports[p] = port(base + p);
					ports[p].data = next_rand();
				end
			end
			@(posedge clock);
			wb <= ports;
			for (int p = 0; p < N; p++) begin
				if (ports[p].en)
					shadow[ports[p].tag] = ports[p].data;
			end
		end
	endtask

	initial begin
		row_t row;
		issue_pkg::word_t pc;

		reset = 1'b1;
		dispatch = '0;
		wb = '0;
		for (int j = 0; j < issue_pkg::N_PHY_REG; j++)
			shadow[j] = '0;
		fill_decode_table();
		fill_main_table();

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		// empty stage right after reset
		row = '0;
		row.exp_num = issue_pkg::cnt_t'(N);
		apply_row(row);

		preload_registers();

		// each class alone in lane 0
		for (int i = 0; i < DEC_ROWS; i++) begin
			pc = issue_pkg::word_t'(DEC_PC + 4 * i);
			row = '0;
			row.lanes[0] = lane(dec_inst[i], pc, 1, 2, 40 + i);
			row.exp_pc[0] = pc;
			row.exp_num = issue_pkg::cnt_t'(N);
			row.exp_tag[0] = dec_ctl[i].dest_valid ? issue_pkg::tag_t'(40 + i) : '0;
			apply_row(row);
			assert (issue_packet[0].ctl == dec_ctl[i]) else begin
				decode_errors++;
				$display("ERR %0t: decode of %h gave ctl %h, expected %h",
					$time, dec_inst[i], issue_packet[0].ctl, dec_ctl[i]);
			end
		end

		for (int r = 0; r < MAIN_ROWS; r++)
			apply_row(rows[r]);

		$display("errors: issue %0d, operand %0d, decode %0d",
			issue_errors, operand_errors, decode_errors);
		if (issue_errors + operand_errors + decode_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== phys_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
	input wire clock,
	input wire issue_pkg::tag_t [issue_pkg::N_WAY-1:0] rda_idx,
	input wire issue_pkg::tag_t [issue_pkg::N_WAY-1:0] rdb_idx,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] rda_out,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] rdb_out,
	input wire issue_pkg::wb_t [issue_pkg::N_WAY-1:0] wb
);

	issue_pkg::word_t regs [issue_pkg::N_PHY_REG];

	// array value, then same-cycle writebacks, higher port last
	function automatic issue_pkg::word_t read_port(input issue_pkg::tag_t tag);
		issue_pkg::word_t value;
		value = regs[tag];
		for (int p = 0; p < issue_pkg::N_WAY; p++) begin
			if (wb[p].en && wb[p].tag == tag)
				value = wb[p].data;
		end
		if (tag == issue_pkg::ZERO_TAG)
			value = '0;
		return value;
	endfunction

	always_comb begin
		for (int i = 0; i < issue_pkg::N_WAY; i++) begin
			rda_out[i] = read_port(rda_idx[i]);
			rdb_out[i] = read_port(rdb_idx[i]);
		end
	end

	// later ports overwrite earlier ones on a tag clash
	always_ff @(posedge clock) begin
		for (int p = 0; p < issue_pkg::N_WAY; p++) begin
			if (wb[p].en && wb[p].tag != issue_pkg::ZERO_TAG)
				regs[wb[p].tag] <= wb[p].data;
		end
	end

endmodule

`default_nettype wire

// ==== ready_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ready_buffer (
	input wire clock,
	input wire reset,
	input wire [issue_pkg::N_WAY-1:0] held_taken,
	input wire [issue_pkg::N_WAY-1:0] fresh_defer,
	input wire issue_pkg::ex_packet_t [issue_pkg::N_WAY-1:0] fresh,
	output issue_pkg::held_entry_t [issue_pkg::N_WAY-1:0] held,
	output issue_pkg::cnt_t free_count
);

	issue_pkg::held_entry_t [issue_pkg::N_WAY-1:0] held_q;
	issue_pkg::held_entry_t [issue_pkg::N_WAY-1:0] held_next;
	logic [issue_pkg::N_WAY-1:0] survive;
	issue_pkg::cnt_t busy_count;

	assign survive = held_q_busy() & ~held_taken;

	function automatic logic [issue_pkg::N_WAY-1:0] held_q_busy();
		logic [issue_pkg::N_WAY-1:0] busy;
		for (int j = 0; j < issue_pkg::N_WAY; j++)
			busy[j] = held_q[j].busy;
		return busy;
	endfunction

	always_comb begin
		issue_pkg::age_t rank;
		issue_pkg::age_t next_age;
		logic placed;

		held_next = held_q;
		next_age = issue_pkg::age_t'(1);

		//////////////////////////////////////////////////
		// compact ages of the survivors
		//////////////////////////////////////////////////
		for (int j = 0; j < issue_pkg::N_WAY; j++) begin
			rank = issue_pkg::age_t'(1);
			for (int k = 0; k < issue_pkg::N_WAY; k++) begin
				if (survive[k] && held_q[k].age < held_q[j].age)
					rank = rank + 1'b1;
			end
			if (survive[j]) begin
				held_next[j].age = rank;
				next_age = next_age + 1'b1;
			end else begin
				held_next[j].busy = 1'b0;
				held_next[j].age = '0;
			end
		end

		//////////////////////////////////////////////////
		// deferred lanes into the lowest free slots
		//////////////////////////////////////////////////
		for (int i = 0; i < issue_pkg::N_WAY; i++) begin
			placed = !fresh_defer[i];
			for (int j = 0; j < issue_pkg::N_WAY; j++) begin
				if (!placed && !held_next[j].busy) begin
					held_next[j].busy = 1'b1;
					held_next[j].age = next_age;
					held_next[j].pkt = fresh[i];
					next_age = next_age + 1'b1;
					placed = 1'b1;
				end
			end
		end

		busy_count = '0;
		for (int j = 0; j < issue_pkg::N_WAY; j++)
			busy_count = busy_count + issue_pkg::cnt_t'(held_next[j].busy);
	end

	// credit for upstream, counted on the next state
	assign free_count = issue_pkg::cnt_t'(issue_pkg::N_WAY) - busy_count;
	assign held = held_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int j = 0; j < issue_pkg::N_WAY; j++) begin
				held_q[j].busy <= 1'b0;
				held_q[j].age <= '0;
			end
		end else begin
			held_q <= held_next;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f issue_stage.f \
	--top-module issue_stage_tb \
	-o issue_stage_sim

./obj_dir/issue_stage_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
